//--- rtl/axi_pkg.sv
package axi_pkg;

  // Field widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 8;
  localparam int unsigned AtopWidth = 6;

  // Vector types with a meaning of their own
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [LenWidth-1:0]  len_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [1:0]           resp_t;

  // Response codes
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlverr = 2'b10;

  // Atop[5:4] encoding for a plain write
  localparam logic [1:0] AtopNone = 2'b00;
  // Atop bit that asks for read data as well
  localparam int unsigned AtopRResp = 5;

  // Write address channel
  typedef struct packed {
    id_t                  id;
    logic [AddrWidth-1:0] addr;
    len_t                 len;
    logic [2:0]           size;
    logic [1:0]           burst;
    logic [AtopWidth-1:0] atop;
  } aw_chan_t;

  // Write data channel, one strobe bit per byte
  typedef struct packed {
    data_t                  data;
    logic [DataWidth/8-1:0] strb;
    logic                   last;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // Read address channel
  typedef struct packed {
    id_t                  id;
    logic [AddrWidth-1:0] addr;
    len_t                 len;
    logic [2:0]           size;
    logic [1:0]           burst;
  } ar_chan_t;

  // Read data channel
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // Manager to subordinate
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

endpackage

//--- rtl/atop_filter_pkg.sv
package atop_filter_pkg;

  // Most AWs downstream still waiting for their W burst
  localparam int unsigned MaxWriteTxns = 4;
  // Holds MaxWriteTxns and all ones stands for minus one
  localparam int unsigned CntWidth = 3;

  // Outstanding AW count with underflow marker
  typedef struct packed {
    logic                underflow;
    logic [CntWidth-1:0] cnt;
  } w_cnt_t;

  // What the read injector needs to answer an atomic AW
  typedef struct packed {
    axi_pkg::id_t  id;
    axi_pkg::len_t len;
  } r_inject_cmd_t;

  // Write side FSM
  typedef enum logic [2:0] {
    W_RESET, W_FEEDTHROUGH, BLOCK_AW, ABSORB_W, HOLD_B, INJECT_B, WAIT_R
  } w_state_e;

  // Read side FSM
  typedef enum logic [1:0] {
    R_RESET, R_FEEDTHROUGH, INJECT_R, R_HOLD
  } r_state_e;

endpackage

//--- rtl/write_burst_tracker.sv
`timescale 1ns/10ps

module write_burst_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic aw_fire_i,
  input  logic w_last_fire_i,
  output logic aw_pending_o,
  output logic w_ahead_o,
  output logic aw_allowed_o
);

  import atop_filter_pkg::*;

  w_cnt_t w_cnt_d, w_cnt_q;

  // Up on AW, down on completed W burst
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (aw_fire_i) begin
      w_cnt_d.cnt = w_cnt_d.cnt + CntWidth'(1);
    end
    if (w_last_fire_i) begin
      w_cnt_d.cnt = w_cnt_d.cnt - CntWidth'(1);
    end
    // Back to zero from minus one clears the flag
    if (w_cnt_q.underflow && (w_cnt_d.cnt == '0)) begin
      w_cnt_d.underflow = 1'b0;
    // Wrap from zero to all ones marks a W burst ahead of its AW
    end else if ((w_cnt_q.cnt == '0) && (&w_cnt_d.cnt)) begin
      w_cnt_d.underflow = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_cnt_q <= '0;
    end else begin
      w_cnt_q <= w_cnt_d;
    end
  end

  // Some AW downstream still misses W beats
  assign aw_pending_o = !w_cnt_q.underflow && (w_cnt_q.cnt != '0);
  // A complete W burst went down before its AW
  assign w_ahead_o    = w_cnt_q.underflow && (&w_cnt_q.cnt);
  // Room for one more AW
  assign aw_allowed_o = w_ahead_o || (w_cnt_q.cnt < CntWidth'(MaxWriteTxns));

endmodule

//--- rtl/atop_write_ctrl.sv
`timescale 1ns/10ps

module atop_write_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Slave port AW, W and B
  input  axi_pkg::aw_chan_t             slv_aw_i,
  input  logic                          slv_aw_valid_i,
  input  logic                          slv_w_valid_i,
  input  logic                          slv_w_last_i,
  input  logic                          slv_b_ready_i,
  // Master port handshakes and B
  input  logic                          mst_aw_ready_i,
  input  logic                          mst_w_ready_i,
  input  logic                          mst_b_valid_i,
  input  axi_pkg::b_chan_t              mst_b_i,
  // Burst tracker status
  input  logic                          aw_pending_i,
  input  logic                          w_ahead_i,
  input  logic                          aw_allowed_i,
  // Read injector busy
  input  logic                          r_pending_i,
  output logic                          mst_aw_valid_o,
  output logic                          mst_w_valid_o,
  output logic                          mst_b_ready_o,
  output logic                          slv_aw_ready_o,
  output logic                          slv_w_ready_o,
  output logic                          slv_b_valid_o,
  output axi_pkg::b_chan_t              slv_b_o,
  // Strobes to the burst tracker
  output logic                          aw_fire_o,
  output logic                          w_last_fire_o,
  // Command to the read injector
  output logic                          r_cmd_push_o,
  output atop_filter_pkg::r_inject_cmd_t r_cmd_o
);

  import axi_pkg::*;
  import atop_filter_pkg::*;

  w_state_e w_state_d, w_state_q;
  id_t      id_q;
  logic     aw_absorb;
  logic     aw_is_atop;
  logic     slv_w_last_beat;
  w_state_e w_done_state;

  assign aw_is_atop      = slv_aw_valid_i && (slv_aw_i.atop[5:4] != AtopNone);
  assign slv_w_last_beat = slv_w_valid_i && slv_w_last_i;
  // After the last absorbed beat, let a stalled forwarded B go first
  assign w_done_state    = (mst_b_valid_i && !slv_b_ready_i) ? HOLD_B : INJECT_B;

  always_comb begin
    // AW and W closed by default
    mst_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    mst_w_valid_o  = 1'b0;
    slv_w_ready_o  = 1'b0;
    // B passes through unless injecting
    mst_b_ready_o  = slv_b_ready_i;
    slv_b_valid_o  = mst_b_valid_i;
    slv_b_o        = mst_b_i;
    aw_absorb      = 1'b0;
    w_state_d      = w_state_q;

    unique case (w_state_q)
      W_RESET: begin
        w_state_d = W_FEEDTHROUGH;
      end

      W_FEEDTHROUGH: begin
        // Admit AWs only below the outstanding limit
        if (aw_allowed_i) begin
          mst_aw_valid_o = slv_aw_valid_i;
          slv_aw_ready_o = mst_aw_ready_i;
        end
        // W may go if downstream waits for it, or a plain AW is on its way
        // and no complete W burst already sits ahead of its AW
        if (aw_pending_i ||
            (slv_aw_valid_i && (slv_aw_i.atop[5:4] == AtopNone) && !w_ahead_i)) begin
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end
        // Atomic AW is swallowed here
        if (aw_is_atop) begin
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b1;
          aw_absorb      = 1'b1;
          if (aw_pending_i) begin
            // Earlier W bursts must drain first
            w_state_d = BLOCK_AW;
          end else begin
            // Nothing owed downstream, absorb right away
            mst_w_valid_o = 1'b0;
            slv_w_ready_o = 1'b1;
            w_state_d     = slv_w_last_beat ? w_done_state : ABSORB_W;
          end
        end
      end

      BLOCK_AW: begin
        if (aw_pending_i) begin
          // Let outstanding bursts finish
          mst_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mst_w_ready_i;
        end else begin
          // Next W burst belongs to the atomic AW
          slv_w_ready_o = 1'b1;
          w_state_d     = slv_w_last_beat ? w_done_state : ABSORB_W;
        end
      end

      ABSORB_W: begin
        // Swallow beats without back-pressure
        slv_w_ready_o = 1'b1;
        if (slv_w_last_beat) begin
          w_state_d = w_done_state;
        end
      end

      HOLD_B: begin
        // Wait for the forwarded B to be taken
        if (mst_b_valid_i && slv_b_ready_i) begin
          w_state_d = INJECT_B;
        end
      end

      INJECT_B: begin
        // Own error response, forwarded B paused
        mst_b_ready_o = 1'b0;
        slv_b_o       = '{id: id_q, resp: RespSlverr};
        slv_b_valid_o = 1'b1;
        if (slv_b_ready_i) begin
          w_state_d = r_pending_i ? WAIT_R : W_FEEDTHROUGH;
        end
      end

      WAIT_R: begin
        // Injected R burst must finish before new writes
        if (!r_pending_i) begin
          w_state_d = W_FEEDTHROUGH;
        end
      end

      default: begin
        w_state_d = W_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= W_RESET;
    end else begin
      w_state_q <= w_state_d;
    end
  end

  // ID of the absorbed atomic AW, used for B and R
  always_ff @(posedge clk_i) begin
    if (aw_absorb) begin
      id_q <= slv_aw_i.id;
    end
  end

  // Master port handshakes for the tracker
  assign aw_fire_o     = mst_aw_valid_o && mst_aw_ready_i;
  assign w_last_fire_o = mst_w_valid_o && mst_w_ready_i && slv_w_last_i;

  // Read data wanted only for some ATOPs
  assign r_cmd_push_o = aw_absorb && slv_aw_i.atop[AtopRResp];
  assign r_cmd_o      = '{id: slv_aw_i.id, len: slv_aw_i.len};

endmodule

//--- rtl/atop_read_inject.sv
`timescale 1ns/10ps

module atop_read_inject (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           r_cmd_push_i,
  input  atop_filter_pkg::r_inject_cmd_t r_cmd_i,
  input  axi_pkg::r_chan_t               mst_r_i,
  input  logic                           mst_r_valid_i,
  input  logic                           slv_r_ready_i,
  output axi_pkg::r_chan_t               slv_r_o,
  output logic                           slv_r_valid_o,
  output logic                           mst_r_ready_o,
  output logic                           r_pending_o
);

  import axi_pkg::*;
  import atop_filter_pkg::*;

  r_state_e      r_state_d, r_state_q;
  r_inject_cmd_t cmd_q;
  logic          cmd_valid_d, cmd_valid_q;
  len_t          beats_d, beats_q;

  always_comb begin
    // Feed R through by default
    slv_r_o       = mst_r_i;
    slv_r_valid_o = mst_r_valid_i;
    mst_r_ready_o = slv_r_ready_i;
    beats_d       = beats_q;
    r_state_d     = r_state_q;
    // New command arms, last injected beat disarms
    cmd_valid_d   = cmd_valid_q | r_cmd_push_i;

    unique case (r_state_q)
      R_RESET: begin
        r_state_d = R_FEEDTHROUGH;
      end

      R_FEEDTHROUGH: begin
        if (mst_r_valid_i && !slv_r_ready_i) begin
          // Forwarded beat stalled, it must finish first
          r_state_d = R_HOLD;
        end else if (cmd_valid_q) begin
          // No ordering against other IDs, start at once
          beats_d   = cmd_q.len;
          r_state_d = INJECT_R;
        end
      end

      INJECT_R: begin
        mst_r_ready_o = 1'b0;
        slv_r_o       = '0;
        slv_r_o.id    = cmd_q.id;
        slv_r_o.resp  = RespSlverr;
        slv_r_o.last  = (beats_q == '0);
        slv_r_valid_o = 1'b1;
        if (slv_r_ready_i) begin
          if (beats_q == '0) begin
            cmd_valid_d = 1'b0;
            r_state_d   = R_FEEDTHROUGH;
          end else begin
            beats_d = beats_q - len_t'(1);
          end
        end
      end

      R_HOLD: begin
        if (mst_r_valid_i && slv_r_ready_i) begin
          r_state_d = R_FEEDTHROUGH;
        end
      end

      default: begin
        r_state_d = R_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_state_q   <= R_RESET;
      cmd_valid_q <= 1'b0;
      beats_q     <= '0;
    end else begin
      r_state_q   <= r_state_d;
      cmd_valid_q <= cmd_valid_d;
      beats_q     <= beats_d;
    end
  end

  // One-entry command store
  always_ff @(posedge clk_i) begin
    if (r_cmd_push_i) begin
      cmd_q <= r_cmd_i;
    end
  end

  assign r_pending_o = cmd_valid_q;

endmodule

//--- rtl/atop_filter.sv
`timescale 1ns/10ps

module atop_filter (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Manager side
  input  axi_pkg::axi_req_t  slv_req_i,
  output axi_pkg::axi_resp_t slv_resp_o,
  // Subordinate side
  output axi_pkg::axi_req_t  mst_req_o,
  input  axi_pkg::axi_resp_t mst_resp_i
);

  import axi_pkg::*;
  import atop_filter_pkg::*;

  // Write controller handshakes
  logic          mst_aw_valid, mst_w_valid, mst_b_ready;
  logic          slv_aw_ready, slv_w_ready, slv_b_valid;
  b_chan_t       slv_b;
  // Tracker strobes and status
  logic          aw_fire, w_last_fire;
  logic          aw_pending, w_ahead, aw_allowed;
  // Read injection
  logic          r_cmd_push, r_pending;
  r_inject_cmd_t r_cmd;
  r_chan_t       slv_r;
  logic          slv_r_valid, mst_r_ready;

  write_burst_tracker u_write_burst_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_fire_i     (aw_fire),
    .w_last_fire_i (w_last_fire),
    .aw_pending_o  (aw_pending),
    .w_ahead_o     (w_ahead),
    .aw_allowed_o  (aw_allowed)
  );

  atop_write_ctrl u_atop_write_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_req_i.aw),
    .slv_aw_valid_i (slv_req_i.aw_valid),
    .slv_w_valid_i  (slv_req_i.w_valid),
    .slv_w_last_i   (slv_req_i.w.last),
    .slv_b_ready_i  (slv_req_i.b_ready),
    .mst_aw_ready_i (mst_resp_i.aw_ready),
    .mst_w_ready_i  (mst_resp_i.w_ready),
    .mst_b_valid_i  (mst_resp_i.b_valid),
    .mst_b_i        (mst_resp_i.b),
    .aw_pending_i   (aw_pending),
    .w_ahead_i      (w_ahead),
    .aw_allowed_i   (aw_allowed),
    .r_pending_i    (r_pending),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_w_valid_o  (mst_w_valid),
    .mst_b_ready_o  (mst_b_ready),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_o        (slv_b),
    .aw_fire_o      (aw_fire),
    .w_last_fire_o  (w_last_fire),
    .r_cmd_push_o   (r_cmd_push),
    .r_cmd_o        (r_cmd)
  );

  atop_read_inject u_atop_read_inject (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .r_cmd_push_i  (r_cmd_push),
    .r_cmd_i       (r_cmd),
    .mst_r_i       (mst_resp_i.r),
    .mst_r_valid_i (mst_resp_i.r_valid),
    .slv_r_ready_i (slv_req_i.r_ready),
    .slv_r_o       (slv_r),
    .slv_r_valid_o (slv_r_valid),
    .mst_r_ready_o (mst_r_ready),
    .r_pending_o   (r_pending)
  );

  // Downstream request, atop always cleared
  always_comb begin
    mst_req_o.aw       = slv_req_i.aw;
    mst_req_o.aw.atop  = '0;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w        = slv_req_i.w;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = mst_b_ready;
    // AR untouched
    mst_req_o.ar       = slv_req_i.ar;
    mst_req_o.ar_valid = slv_req_i.ar_valid;
    mst_req_o.r_ready  = mst_r_ready;
  end

  // Upstream response
  always_comb begin
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    slv_resp_o.b        = slv_b;
    slv_resp_o.b_valid  = slv_b_valid;
    slv_resp_o.ar_ready = mst_resp_i.ar_ready;
    slv_resp_o.r        = slv_r;
    slv_resp_o.r_valid  = slv_r_valid;
  end

endmodule

//--- bench/atop_filter_checker.sv
`timescale 1ns/10ps

module atop_filter_checker (
  input logic               clk_i,
  input logic               rst_ni,
  input axi_pkg::axi_req_t  slv_req_i,
  input axi_pkg::axi_resp_t slv_resp_i,
  input axi_pkg::axi_req_t  mst_req_i,
  input axi_pkg::axi_resp_t mst_resp_i
);

  import axi_pkg::*;

  // Failed assertions so far, watched by the testbench
  int unsigned fails = 0;

  // Only plain AWs from the slave port leave on the master port, atop cleared
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_req_i.aw_valid |->
      ((mst_req_i.aw.atop == '0) && slv_req_i.aw_valid &&
       (slv_req_i.aw.atop[5:4] == AtopNone)))
    else begin
      $error("Atomic AW or uncleared atop on master port AW");
      fails++;
    end

  // B valid and payload held until accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_resp_i.b_valid && !slv_req_i.b_ready) |=>
      (slv_resp_i.b_valid && $stable(slv_resp_i.b)))
    else begin
      $error("Slave port B dropped or changed before ready");
      fails++;
    end

  // Same for R, injected or forwarded
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_resp_i.r_valid && !slv_req_i.r_ready) |=>
      (slv_resp_i.r_valid && $stable(slv_resp_i.r)))
    else begin
      $error("Slave port R dropped or changed before ready");
      fails++;
    end

  // Write path closed while the FSMs sit in their reset state
  assert property (@(posedge clk_i) $rose(rst_ni) |->
    !(slv_resp_i.aw_ready || slv_resp_i.w_ready || mst_req_i.aw_valid || mst_req_i.w_valid))
    else begin
      $error("Write handshakes open in the first cycle after reset");
      fails++;
    end

endmodule

bind atop_filter atop_filter_checker u_atop_filter_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .slv_req_i  (slv_req_i),
  .slv_resp_i (slv_resp_o),
  .mst_req_i  (mst_req_o),
  .mst_resp_i (mst_resp_i)
);

//--- bench/atop_filter_tb.sv
`timescale 1ns/10ps

module atop_filter_tb;

  import axi_pkg::*;
  import atop_filter_pkg::*;

  localparam int unsigned NumTxns = 23;
  // Four byte beats, incrementing bursts
  localparam logic [2:0] BeatSize  = 3'd2;
  localparam logic [1:0] BurstIncr = 2'b01;

  // Expected outcome of one write
  typedef struct packed {
    id_t        id;
    resp_t      resp;
    logic [8:0] r_beats;
    logic       at_mst;
  } exp_t;

  // W burst still to be sent by the manager
  typedef struct packed {
    id_t  id;
    len_t len;
  } wburst_t;

  logic      clk_i = 1'b0;
  logic      rst_ni = 1'b0;
  axi_req_t  slv_req, mst_req;
  axi_resp_t slv_resp, mst_resp;
  // Manager side
  aw_chan_t  m_aw = '0;
  w_chan_t   m_w = '0;
  ar_chan_t  m_ar = '0;
  logic      m_aw_valid = 1'b0, m_w_valid = 1'b0, m_ar_valid = 1'b0;
  logic      m_b_ready = 1'b0, m_r_ready = 1'b0;
  // Subordinate side
  b_chan_t   s_b = '0;
  r_chan_t   s_r = '0;
  logic      s_aw_ready = 1'b0, s_w_ready = 1'b0, s_ar_ready = 1'b0;
  logic      s_b_valid = 1'b0, s_r_valid = 1'b0;
  logic      w_stall = 1'b0;
  integer    seed = 32'h6bed3ba6;
  // Subordinate model state
  id_t       sub_bid_q[$];
  ar_chan_t  sub_ar_q[$];
  int        sub_wdone = 0, sub_rbeat = 0;
  // Expectations per id
  logic        b_pend[16] = '{default: 1'b0};
  logic        r_inj[16] = '{default: 1'b0};
  logic        mst_exp[16] = '{default: 1'b0};
  logic        mst_seen[16] = '{default: 1'b0};
  resp_t       b_exp[16];
  int          r_left[16] = '{default: 0};
  int          r_beat[16] = '{default: 0};
  logic [31:0] exp_addr[16];
  len_t        exp_len[16];
  w_chan_t     exp_w_q[$];
  wburst_t     w_q[$];
  int          resp_left = 0, mst_outst = 0, next_id = 0, txn_cnt = 0;

  always #50 clk_i = ~clk_i;

  assign slv_req = '{aw: m_aw, aw_valid: m_aw_valid, w: m_w, w_valid: m_w_valid,
                     b_ready: m_b_ready, ar: m_ar, ar_valid: m_ar_valid, r_ready: m_r_ready};
  assign mst_resp = '{aw_ready: s_aw_ready, w_ready: s_w_ready, b: s_b, b_valid: s_b_valid,
                      ar_ready: s_ar_ready, r: s_r, r_valid: s_r_valid};

  atop_filter u_atop_filter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp)
  );

  // Plain writes go down with OKAY, ATOPs get SLVERR and maybe R data
  function automatic exp_t expected_resp(logic [AtopWidth-1:0] atop, id_t id, len_t len);
    exp_t e;
    e.id = id;
    if (atop[5:4] == AtopNone) begin
      e.resp    = RespOkay;
      e.r_beats = 9'd0;
      e.at_mst  = 1'b1;
    end else begin
      e.resp    = RespSlverr;
      e.r_beats = atop[AtopRResp] ? (9'(len) + 9'd1) : 9'd0;
      e.at_mst  = 1'b0;
    end
    return e;
  endfunction

  function automatic data_t write_data(id_t id, int beat);
    return {4'hd, id, 16'(beat), 8'h3c};
  endfunction

  // Subordinate read data pattern
  function automatic data_t read_data(logic [31:0] addr, int beat);
    return (addr + 32'(beat * 4)) ^ 32'h5a5a_0000;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    stop_on_error($sformatf("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, act_v));
  endtask

  // Next id, once all its earlier responses are in
  task automatic alloc_id(output id_t id);
    id = id_t'(next_id);
    next_id++;
    txn_cnt++;
    @(posedge clk_i);
    while (b_pend[id] || (r_left[id] != 0)) @(posedge clk_i);
  endtask

  task automatic write_txn(input logic [AtopWidth-1:0] atop, input len_t len);
    id_t  id;
    exp_t e;
    alloc_id(id);
    e = expected_resp(atop, id, len);
    b_pend[id]   = 1'b1;
    b_exp[id]    = e.resp;
    r_left[id]   = e.r_beats;
    r_beat[id]   = 0;
    r_inj[id]    = 1'b1;
    mst_exp[id]  = e.at_mst;
    mst_seen[id] = 1'b0;
    exp_addr[id] = 32'h1000_0000 + 32'(txn_cnt << 6);
    exp_len[id]  = len;
    resp_left += (e.r_beats != 0) ? 2 : 1;
    for (int i = 0; i <= int'(len); i++) begin
      if (e.at_mst) begin
        exp_w_q.push_back('{data: write_data(id, i), strb: '1, last: (i == int'(len))});
      end
    end
    w_q.push_back('{id: id, len: len});
    m_aw <= '{id: id, addr: exp_addr[id], len: len, size: BeatSize, burst: BurstIncr,
              atop: atop};
    m_aw_valid <= 1'b1;
    @(posedge clk_i);
    while (!slv_resp.aw_ready) @(posedge clk_i);
    m_aw_valid <= 1'b0;
  endtask

  task automatic read_txn(input len_t len);
    id_t id;
    alloc_id(id);
    r_left[id]   = int'(len) + 1;
    r_beat[id]   = 0;
    r_inj[id]    = 1'b0;
    mst_exp[id]  = 1'b0;
    exp_addr[id] = 32'h2000_0000 + 32'(txn_cnt << 6);
    exp_len[id]  = len;
    resp_left++;
    m_ar <= '{id: id, addr: exp_addr[id], len: len, size: BeatSize, burst: BurstIncr};
    m_ar_valid <= 1'b1;
    @(posedge clk_i);
    while (!slv_resp.ar_ready) @(posedge clk_i);
    m_ar_valid <= 1'b0;
  endtask

  // W bursts in AW issue order
  initial begin : w_driver
    wburst_t wb;
    forever begin
      @(posedge clk_i);
      if (w_q.size() > 0) begin
        wb = w_q.pop_front();
        for (int i = 0; i <= int'(wb.len); i++) begin
          m_w <= '{data: write_data(wb.id, i), strb: '1, last: (i == int'(wb.len))};
          m_w_valid <= 1'b1;
          @(posedge clk_i);
          while (!slv_resp.w_ready) @(posedge clk_i);
        end
        m_w_valid <= 1'b0;
      end
    end
  end

  // Random back-pressure on both ports
  always @(posedge clk_i) begin : ready_gen
    s_aw_ready <= w_stall || (($random(seed) & 3) != 0);
    s_w_ready  <= !w_stall && (($random(seed) & 3) != 0);
    s_ar_ready <= ($random(seed) & 3) != 0;
    m_b_ready  <= ($random(seed) & 1) != 0;
    m_r_ready  <= ($random(seed) & 1) != 0;
  end

  // B per AW in order once its W burst is in, R beats counted per AR
  always @(posedge clk_i) begin : subordinate
    if (rst_ni) begin
      if (s_b_valid && mst_req.b_ready) begin
        void'(sub_bid_q.pop_front());
        sub_wdone--;
      end
      if (mst_req.aw_valid && s_aw_ready) sub_bid_q.push_back(mst_req.aw.id);
      if (mst_req.w_valid && s_w_ready && mst_req.w.last) sub_wdone++;
      s_b_valid <= (sub_bid_q.size() > 0) && (sub_wdone > 0);
      if (sub_bid_q.size() > 0) s_b <= '{id: sub_bid_q[0], resp: RespOkay};
      if (s_r_valid && mst_req.r_ready) begin
        if (s_r.last) begin
          void'(sub_ar_q.pop_front());
          sub_rbeat = 0;
        end else begin
          sub_rbeat++;
        end
      end
      if (mst_req.ar_valid && s_ar_ready) sub_ar_q.push_back(mst_req.ar);
      s_r_valid <= (sub_ar_q.size() > 0);
      if (sub_ar_q.size() > 0) begin
        s_r <= '{id: sub_ar_q[0].id, data: read_data(sub_ar_q[0].addr, sub_rbeat),
                 resp: RespOkay, last: (sub_rbeat == int'(sub_ar_q[0].len))};
      end
    end
  end

  // Compares every handshake on both ports with the expectations
  always @(posedge clk_i) begin : scoreboard
    id_t   id;
    data_t exp_d;
    if (rst_ni) begin
      assert (u_atop_filter.u_atop_filter_checker.fails == 0)
        else stop_on_error("A protocol assertion on the filter ports failed");
      if (slv_resp.b_valid && m_b_ready) begin
        id = slv_resp.b.id;
        assert (b_pend[id]) else stop_on_error($sformatf("B with unexpected id %0d", id));
        assert (slv_resp.b.resp == b_exp[id])
          else report_mismatch("slv_resp_o.b.resp", b_exp[id], slv_resp.b.resp);
        assert (mst_seen[id] == mst_exp[id])
          else report_mismatch("mst_req_o.aw reached", mst_exp[id], mst_seen[id]);
        b_pend[id] = 1'b0;
        resp_left--;
      end
      if (slv_resp.r_valid && m_r_ready) begin
        id = slv_resp.r.id;
        assert (r_left[id] != 0) else stop_on_error($sformatf("R with unexpected id %0d", id));
        exp_d = r_inj[id] ? '0 : read_data(exp_addr[id], r_beat[id]);
        assert (slv_resp.r.data == exp_d)
          else report_mismatch("slv_resp_o.r.data", exp_d, slv_resp.r.data);
        assert (slv_resp.r.resp == (r_inj[id] ? RespSlverr : RespOkay))
          else report_mismatch("slv_resp_o.r.resp", r_inj[id] ? RespSlverr : RespOkay,
                               slv_resp.r.resp);
        assert (slv_resp.r.last == (r_left[id] == 1))
          else report_mismatch("slv_resp_o.r.last", r_left[id] == 1, slv_resp.r.last);
        r_beat[id]++;
        r_left[id]--;
        if (r_left[id] == 0) resp_left--;
      end
      if (mst_req.aw_valid && mst_resp.aw_ready) begin
        id = mst_req.aw.id;
        assert (mst_exp[id] && !mst_seen[id])
          else stop_on_error($sformatf("AW id %0d reached the master port unexpectedly", id));
        assert (mst_req.aw.addr == exp_addr[id])
          else report_mismatch("mst_req_o.aw.addr", exp_addr[id], mst_req.aw.addr);
        assert (mst_req.aw.len == exp_len[id])
          else report_mismatch("mst_req_o.aw.len", exp_len[id], mst_req.aw.len);
        assert (mst_req.aw.size == BeatSize)
          else report_mismatch("mst_req_o.aw.size", BeatSize, mst_req.aw.size);
        assert (mst_req.aw.burst == BurstIncr)
          else report_mismatch("mst_req_o.aw.burst", BurstIncr, mst_req.aw.burst);
        mst_seen[id] = 1'b1;
        mst_outst++;
      end
      if (mst_req.w_valid && mst_resp.w_ready) begin
        assert (exp_w_q.size() > 0) else stop_on_error("W beat at master port with none due");
        assert (mst_req.w.data == exp_w_q[0].data)
          else report_mismatch("mst_req_o.w.data", exp_w_q[0].data, mst_req.w.data);
        assert (mst_req.w.strb == exp_w_q[0].strb)
          else report_mismatch("mst_req_o.w.strb", exp_w_q[0].strb, mst_req.w.strb);
        assert (mst_req.w.last == exp_w_q[0].last)
          else report_mismatch("mst_req_o.w.last", exp_w_q[0].last, mst_req.w.last);
        if (mst_req.w.last) mst_outst--;
        void'(exp_w_q.pop_front());
      end
      if (mst_req.ar_valid && mst_resp.ar_ready) begin
        id = mst_req.ar.id;
        assert (mst_req.ar.addr == exp_addr[id])
          else report_mismatch("mst_req_o.ar.addr", exp_addr[id], mst_req.ar.addr);
        assert (mst_req.ar.len == exp_len[id])
          else report_mismatch("mst_req_o.ar.len", exp_len[id], mst_req.ar.len);
        assert (mst_req.ar.size == BeatSize)
          else report_mismatch("mst_req_o.ar.size", BeatSize, mst_req.ar.size);
        assert (mst_req.ar.burst == BurstIncr)
          else report_mismatch("mst_req_o.ar.burst", BurstIncr, mst_req.ar.burst);
      end
      assert (mst_outst <= int'(MaxWriteTxns))
        else report_mismatch("outstanding AWs at master port", MaxWriteTxns, mst_outst);
    end
  end

  initial begin : watchdog
    repeat (NumTxns * 40) @(posedge clk_i);
    stop_on_error("Timeout, the transactions did not complete in time");
  end

  initial begin : main
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Plain writes
    write_txn(6'h00, 8'd0);
    write_txn(6'h00, 8'd3);
    // Atomic store, B only
    write_txn(6'h12, 8'd2);
    // Atomic load and swap, B plus R burst
    write_txn(6'h21, 8'd3);
    write_txn(6'h30, 8'd0);
    read_txn(8'd3);
    read_txn(8'd0);
    // Reads interleaved with an injected R burst
    fork
      begin
        read_txn(8'd2);
        read_txn(8'd4);
        read_txn(8'd1);
      end
      begin
        write_txn(6'h24, 8'd2);
        write_txn(6'h00, 8'd1);
      end
    join
    // Downstream W stalled, AW count hits the limit
    w_stall <= 1'b1;
    fork
      repeat (6) write_txn(6'h00, 8'd1);
      begin
        repeat (30) @(posedge clk_i);
        w_stall <= 1'b0;
      end
    join
    // ATOPs behind W bursts still owed downstream
    w_stall <= 1'b1;
    fork
      begin
        write_txn(6'h00, 8'd3);
        write_txn(6'h00, 8'd2);
        write_txn(6'h21, 8'd3);
        write_txn(6'h12, 8'd1);
        write_txn(6'h00, 8'd0);
      end
      begin
        repeat (25) @(posedge clk_i);
        w_stall <= 1'b0;
      end
    join
    while ((resp_left != 0) || (exp_w_q.size() != 0)) @(posedge clk_i);
    // Port assertions of the last handshake cycle land one edge later
    @(posedge clk_i);
    if ((mst_outst == 0) && (w_q.size() == 0) &&
        (u_atop_filter.u_atop_filter_checker.fails == 0)) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_on_error("Write bursts left open or a port assertion failed at the end of the run");
    end
  end

endmodule

//--- all.f
rtl/axi_pkg.sv
rtl/atop_filter_pkg.sv
rtl/write_burst_tracker.sv
rtl/atop_write_ctrl.sv
rtl/atop_read_inject.sv
rtl/atop_filter.sv
bench/atop_filter_checker.sv
bench/atop_filter_tb.sv
